// ==== common/ifq_defines.svh ====
/* sizes and flag thresholds of the parcel queue, included by the
   queue, the aligner and the top level */

`ifndef IFQ_DEFINES_SVH
`define IFQ_DEFINES_SVH

// queue capacity in 16 bit parcels
`define IFQ_DEPTH 8

// parcels per bus word written into the queue
`define IFQ_WR_PARCELS 2

// most parcels the aligner pulls at once
`define IFQ_RD_PARCELS 2

// almost empty below two parcels held
`define IFQ_ALMOST_EMPTY 1
// depth here selects the plain full rule
`define IFQ_ALMOST_FULL `IFQ_DEPTH

`endif

// ==== common/ifq_pkg.sv ====
/* types shared by the fetch front end: the instruction parcel and the
   two views of a 32 bit fetch word */

package ifq_pkg;

  // one compressed instruction or half of a full one
  typedef logic [15:0] parcel_t;

  // word seen as two parcels, low parcel at the lower address
  typedef struct packed {
    parcel_t hi;
    parcel_t lo;
  } parcel_pair_t;

  // word seen as an instruction
  // len is 2'b11 for a 32 bit instruction, anything else is compressed
  typedef struct packed {
    logic [29:0] body;
    logic [1:0]  len;
  } instr_view_t;

  // same bits, decoded either way
  typedef union packed {
    parcel_pair_t parcels;
    instr_view_t  instr;
  } fetch_word_u;

  // length code of a full instruction
  localparam logic [1:0] LEN_FULL = 2'b11;

endpackage

// ==== common/parcel_if.sv ====
/* write side of the parcel queue; the fetch controller pushes words
   and flushes, the queue reports back how full it is */

`include "ifq_defines.svh"

interface parcel_if
  import ifq_pkg::*;
();

  parcel_t [`IFQ_WR_PARCELS-1:0] parcel;
  logic    [`IFQ_WR_PARCELS-1:0] parcel_valid;
  logic                          parcel_err;
  // one cycle write strobe
  logic                          push;
  logic                          flush;
  logic                          full;
  logic                          almost_full;

  modport producer (output parcel, parcel_valid, parcel_err, push, flush,
                    input  full, almost_full);

  modport consumer (input  parcel, parcel_valid, parcel_err, push, flush,
                    output full, almost_full);

endinterface

// ==== hw/parcel_queue/parcel_queue.sv ====
/* parcel queue between fetch controller and aligner; words come in over
   parcel_if, one or two parcels leave from the head each read */

`include "ifq_defines.svh"

module parcel_queue
  import ifq_pkg::*;
#(
  parameter int DEPTH                  = `IFQ_DEPTH,
  parameter int ALMOST_EMPTY_THRESHOLD = `IFQ_ALMOST_EMPTY,
  parameter int ALMOST_FULL_THRESHOLD  = `IFQ_ALMOST_FULL
)
(
  input  logic                             clk_i,
  input  logic                             rst_ni,
  parcel_if.consumer                       wr_if,
  input  logic [$clog2(`IFQ_RD_PARCELS):0] parcel_rd_i,
  output parcel_t [`IFQ_RD_PARCELS-1:0]    parcel_q_o,
  output logic                             head_err_o,
  output logic                             empty_o,
  output logic                             almost_empty_o
);

  localparam int WR_N = `IFQ_WR_PARCELS;
  localparam int RD_N = `IFQ_RD_PARCELS;
  localparam int AW   = $clog2(DEPTH) + 1;

  // flag levels on the write pointer
  localparam int AEMPTY_LVL = (ALMOST_EMPTY_THRESHOLD <= 0) ? 1 : ALMOST_EMPTY_THRESHOLD + 1;
  localparam int FULL_LVL   = DEPTH - WR_N;
  localparam int AFULL_LVL  = (ALMOST_FULL_THRESHOLD >= DEPTH) ? FULL_LVL
                                                                : ALMOST_FULL_THRESHOLD - WR_N;

  // invalid parcels in front of the first valid one
  function automatic int unsigned lead_invalid(input logic [WR_N-1:0] v);
    int unsigned cnt;
    logic        hit;
    cnt = 0;
    hit = 1'b0;
    for (int n = 0; n < WR_N; n++)
    begin
      if (v[n])
        hit = 1'b1;
      else if (!hit)
        cnt++;
    end
    return cnt;
  endfunction

  function automatic int unsigned count_valid(input logic [WR_N-1:0] v);
    int unsigned cnt;
    cnt = 0;
    for (int n = 0; n < WR_N; n++)
      cnt += v[n];
    return cnt;
  endfunction

  parcel_t [DEPTH-1:0] parcel_sr;
  parcel_t [DEPTH-1:0] nxt_parcel_sr;
  logic    [DEPTH-1:0] err_sr;
  logic    [DEPTH-1:0] nxt_err_sr;
  parcel_t [WR_N-1:0]  wr_parcel;
  logic    [AW-1:0]    wr_cnt;
  logic    [AW-1:0]    wadr;
  logic    [AW-1:0]    nxt_wadr;

  //////////////////////////////////////////////////////////////////////
  // write alignment and pointer

  // drop leading invalid parcels, e.g. entry at a halfword offset
  assign wr_parcel = wr_if.parcel >> (lead_invalid(wr_if.parcel_valid) * 16);
  assign wr_cnt    = wr_if.push ? AW'(count_valid(wr_if.parcel_valid)) : '0;
  assign nxt_wadr  = wadr + wr_cnt - AW'(parcel_rd_i);

  //////////////////////////////////////////////////////////////////////
  // shift register, write first then shift out the read parcels

  always_comb
  begin
    nxt_parcel_sr = parcel_sr;
    nxt_err_sr    = err_sr;
    for (int n = 0; n < WR_N; n++)
    begin
      if ((n < wr_cnt) && (wadr + n < DEPTH))
      begin
        nxt_parcel_sr[wadr + n] = wr_parcel[n];
        nxt_err_sr[wadr + n]    = wr_if.parcel_err;
      end
    end
    nxt_parcel_sr = nxt_parcel_sr >> (parcel_rd_i * 16);
    nxt_err_sr    = nxt_err_sr >> parcel_rd_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_if.flush)
    begin
      parcel_sr <= '0;
      err_sr    <= '0;
    end
    else
    begin
      parcel_sr <= nxt_parcel_sr;
      err_sr    <= nxt_err_sr;
    end
  end

  // head parcels, error only of the parcel an instruction starts in
  assign parcel_q_o = parcel_sr[RD_N-1:0];
  assign head_err_o = err_sr[0];

  //////////////////////////////////////////////////////////////////////
  // pointer and flags, all from the next write pointer

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wadr              <= '0;
      empty_o           <= 1'b1;
      almost_empty_o    <= 1'b1;
      wr_if.full        <= 1'b0;
      wr_if.almost_full <= 1'b0;
    end
    else if (wr_if.flush)
    begin
      wadr              <= '0;
      empty_o           <= 1'b1;
      almost_empty_o    <= 1'b1;
      wr_if.full        <= 1'b0;
      wr_if.almost_full <= 1'b0;
    end
    else
    begin
      wadr              <= nxt_wadr;
      empty_o           <= (nxt_wadr == '0);
      almost_empty_o    <= (nxt_wadr < AEMPTY_LVL);
      // full once another word would not fit
      wr_if.full        <= (nxt_wadr > FULL_LVL);
      wr_if.almost_full <= (nxt_wadr > AFULL_LVL);
    end
  end

endmodule

// ==== hw/fetch_ctrl/fetch_ctrl.sv ====
/* fetch controller; four-phase bus master that reads 32 bit words and
   pushes both halves into the parcel queue, restarted by redirect */

module fetch_ctrl
  import ifq_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        redirect_i,
  input  logic [31:0] redirect_pc_i,
  output logic        mem_req_o,
  output logic [31:0] mem_addr_o,
  input  logic        mem_ack_i,
  input  logic [31:0] mem_rdata_i,
  input  logic        mem_err_i,
  parcel_if.producer  wr_if
);

  logic [31:0] fetch_pc;
  logic        req_q;
  logic        push_q;
  // answer of a request made before a redirect
  logic        discard_q;
  // word entered at its upper half
  logic        offset_q;
  logic        err_q;
  fetch_word_u word_q;
  logic        start;
  logic        done;

  // new request only once ack is low and the last word is in the queue
  assign start = ~req_q & ~push_q & ~mem_ack_i & ~redirect_i
               & ~wr_if.full & ~wr_if.almost_full;
  assign done  = req_q & mem_ack_i;

  //////////////////////////////////////////////////////////////////////
  // bus handshake and fetch address

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      req_q     <= 1'b0;
      push_q    <= 1'b0;
      discard_q <= 1'b0;
      fetch_pc  <= '0;
    end
    else
    begin
      push_q <= done & ~discard_q & ~redirect_i;
      if (start)
        req_q <= 1'b1;
      else if (done)
        req_q <= 1'b0;
      // request in flight keeps its handshake, data is dropped
      if (done)
        discard_q <= 1'b0;
      else if (redirect_i && req_q)
        discard_q <= 1'b1;
      if (redirect_i)
        fetch_pc <= redirect_pc_i;
      else if (done && !discard_q)
        fetch_pc <= {fetch_pc[31:2] + 30'd1, 2'b00};
    end
  end

  // address held for the whole request
  always_ff @(posedge clk_i)
  begin
    if (start)
    begin
      mem_addr_o <= {fetch_pc[31:2], 2'b00};
      offset_q   <= fetch_pc[1];
    end
    if (done)
    begin
      word_q <= mem_rdata_i;
      err_q  <= mem_err_i;
    end
  end

  assign mem_req_o          = req_q;
  assign wr_if.parcel       = {word_q.parcels.hi, word_q.parcels.lo};
  assign wr_if.parcel_valid = {1'b1, ~offset_q};
  assign wr_if.parcel_err   = err_q;
  assign wr_if.push         = push_q;
  assign wr_if.flush        = redirect_i;

endmodule

// ==== hw/instr_aligner/instr_aligner.sv ====
/* instruction aligner; takes one or two parcels from the queue head,
   tracks the PC and offers each instruction over a four-phase handshake */

`include "ifq_defines.svh"

module instr_aligner
  import ifq_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 redirect_i,
  input  logic [31:0]                          redirect_pc_i,
  input  parcel_t [`IFQ_RD_PARCELS-1:0]        parcel_q_i,
  input  logic                                 head_err_i,
  input  logic                                 empty_i,
  input  logic                                 almost_empty_i,
  output logic [$clog2(`IFQ_RD_PARCELS):0]     parcel_rd_o,
  output logic                                 instr_req_o,
  input  logic                                 instr_ack_i,
  output logic [31:0]                          instr_o,
  output logic [31:0]                          instr_pc_o,
  output logic                                 instr_compressed_o,
  output logic                                 instr_err_o
);

  localparam int RD_W = $clog2(`IFQ_RD_PARCELS) + 1;

  fetch_word_u head_word;
  fetch_word_u instr_q;
  logic [31:0] pc_q;
  logic        req_q;
  logic        cmp_q;
  logic        err_q;
  logic        head_full;
  logic        ready;
  logic        issue;
  logic        taken;

  assign head_word = {parcel_q_i[1], parcel_q_i[0]};
  assign head_full = (head_word.instr.len == LEN_FULL);
  // full instruction needs both parcels present
  assign ready     = head_full ? ~almost_empty_i : ~empty_i;
  // no issue while a read is still on its way to the head
  assign issue     = ~req_q & (parcel_rd_o == '0) & ~instr_ack_i & ready & ~redirect_i;
  assign taken     = req_q & instr_ack_i & ~redirect_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      req_q       <= 1'b0;
      parcel_rd_o <= '0;
      pc_q        <= '0;
    end
    else
    begin
      parcel_rd_o <= '0;
      // redirect withdraws any offered instruction
      if (redirect_i)
      begin
        req_q <= 1'b0;
        pc_q  <= redirect_pc_i;
      end
      else if (taken)
      begin
        req_q       <= 1'b0;
        parcel_rd_o <= cmp_q ? RD_W'(1) : RD_W'(2);
        pc_q        <= pc_q + (cmp_q ? 32'd2 : 32'd4);
      end
      else if (issue)
        req_q <= 1'b1;
    end
  end

  // held stable until the handshake ends
  always_ff @(posedge clk_i)
  begin
    if (issue)
    begin
      instr_q <= head_full ? head_word : fetch_word_u'({16'h0000, head_word.parcels.lo});
      cmp_q   <= ~head_full;
      err_q   <= head_err_i;
    end
  end

  assign instr_req_o        = req_q;
  assign instr_o            = instr_q;
  assign instr_pc_o         = pc_q;
  assign instr_compressed_o = cmp_q;
  assign instr_err_o        = err_q;

endmodule

// ==== hw/fetch_frontend.sv ====
/* instruction fetch front end between instruction memory and core;
   connects fetch controller, parcel queue and aligner */

`include "ifq_defines.svh"

module fetch_frontend
  import ifq_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        redirect_i,
  input  logic [31:0] redirect_pc_i,
  // memory bus
  output logic        mem_req_o,
  output logic [31:0] mem_addr_o,
  input  logic        mem_ack_i,
  input  logic [31:0] mem_rdata_i,
  input  logic        mem_err_i,
  // instructions to the core
  output logic        instr_req_o,
  input  logic        instr_ack_i,
  output logic [31:0] instr_o,
  output logic [31:0] instr_pc_o,
  output logic        instr_compressed_o,
  output logic        instr_err_o
);

  parcel_if wr_if ();

  parcel_t [`IFQ_RD_PARCELS-1:0]    parcel_q;
  logic [$clog2(`IFQ_RD_PARCELS):0] rd_cnt;
  logic                             head_err;
  logic                             empty;
  logic                             almost_empty;

  fetch_ctrl i_fetch_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_ack_i     (mem_ack_i),
    .mem_rdata_i   (mem_rdata_i),
    .mem_err_i     (mem_err_i),
    .wr_if         (wr_if.producer)
  );

  parcel_queue #(
    .DEPTH                  (`IFQ_DEPTH),
    .ALMOST_EMPTY_THRESHOLD (`IFQ_ALMOST_EMPTY),
    .ALMOST_FULL_THRESHOLD  (`IFQ_ALMOST_FULL)
  ) i_parcel_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .wr_if          (wr_if.consumer),
    .parcel_rd_i    (rd_cnt),
    .parcel_q_o     (parcel_q),
    .head_err_o     (head_err),
    .empty_o        (empty),
    .almost_empty_o (almost_empty)
  );

  instr_aligner i_instr_aligner (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .redirect_i         (redirect_i),
    .redirect_pc_i      (redirect_pc_i),
    .parcel_q_i         (parcel_q),
    .head_err_i         (head_err),
    .empty_i            (empty),
    .almost_empty_i     (almost_empty),
    .parcel_rd_o        (rd_cnt),
    .instr_req_o        (instr_req_o),
    .instr_ack_i        (instr_ack_i),
    .instr_o            (instr_o),
    .instr_pc_o         (instr_pc_o),
    .instr_compressed_o (instr_compressed_o),
    .instr_err_o        (instr_err_o)
  );

endmodule

// ==== verif/fetch_frontend_properties.sv ====
/* concurrent checks on the memory bus, the instruction handshake and
   the queue flags; bound into the fetch front end by the testbench */

module fetch_frontend_properties
(
  input logic        clk_i,
  input logic        rst_ni,
  input logic        redirect_i,
  input logic        mem_req_i,
  input logic [31:0] mem_addr_i,
  input logic        mem_ack_i,
  input logic        instr_req_i,
  input logic        instr_ack_i,
  input logic [31:0] instr_i,
  input logic [31:0] instr_pc_i,
  input logic        instr_compressed_i,
  input logic        empty_i,
  input logic        almost_empty_i,
  input logic        full_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // failed checks so far, watched from the testbench
  int unsigned fail_cnt = 0;

  // both requests idle and queue empty once reset is released
  reset_state_a: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !mem_req_i && !instr_req_i && empty_i)
  else
  begin
    fail_cnt++;
    $error("outputs not idle or queue not empty after reset");
  end

  // request and address held until memory answers
  mem_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i && !mem_ack_i |=> mem_req_i && $stable(mem_addr_i))
  else
  begin
    fail_cnt++;
    $error("mem_req_o dropped or mem_addr_o moved before mem_ack_i");
  end

  // new request only after ack is low and with room in the queue
  mem_start_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(mem_req_i) |-> !$past(mem_ack_i) && !$past(full_i))
  else
  begin
    fail_cnt++;
    $error("mem_req_o rose while mem_ack_i high or queue full");
  end

  // offered instruction stays stable until ack or redirect
  instr_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_i && !instr_ack_i && !redirect_i
      |=> instr_req_i && $stable(instr_i) && $stable(instr_pc_i))
  else
  begin
    fail_cnt++;
    $error("instruction request withdrawn or changed without ack");
  end

  // four-phase order on the core side
  instr_order_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ($rose(instr_req_i) |-> !$past(instr_ack_i))
    and ($fell(instr_req_i) |-> $past(instr_ack_i) || $past(redirect_i)))
  else
  begin
    fail_cnt++;
    $error("instruction handshake out of four-phase order");
  end

  // offered instruction was complete in the queue, two parcels for a full one
  queue_head_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(instr_req_i) |-> !$past(empty_i)
      && (instr_compressed_i || !$past(almost_empty_i)))
  else
  begin
    fail_cnt++;
    $error("instruction offered before the queue held all its parcels");
  end

endmodule

// ==== verif/fetch_frontend_tb.sv ====
/* testbench for the fetch front end; memory and core models run from the
   golden file, which also holds the expected instruction stream */

module fetch_frontend_tb
  import ifq_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam string GOLDEN_FILE = "verif/fetch_frontend_golden.txt";

  logic        clk_i;
  logic        rst_ni;
  logic        redirect_i;
  logic [31:0] redirect_pc_i;
  logic        mem_req_o;
  logic [31:0] mem_addr_o;
  logic        mem_ack_i;
  logic [31:0] mem_rdata_i;
  logic        mem_err_i;
  logic        instr_req_o;
  logic        instr_ack_i;
  logic [31:0] instr_o;
  logic [31:0] instr_pc_o;
  logic        instr_compressed_o;
  logic        instr_err_o;

  // memory image from the golden file
  logic [31:0] img_addr[$];
  logic [31:0] img_data[$];
  logic        img_err[$];
  // expected stream, one entry per instruction
  logic [31:0] exp_pc[$];
  logic [31:0] exp_instr[$];
  logic        exp_cmp[$];
  logic        exp_err[$];
  int unsigned exp_delay[$];
  int unsigned redirect_after;
  logic [31:0] redirect_target;
  int unsigned watchdog_cycles;

  fetch_frontend i_fetch_frontend (.*);

  bind fetch_frontend fetch_frontend_properties i_fetch_frontend_properties (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .redirect_i         (redirect_i),
    .mem_req_i          (mem_req_o),
    .mem_addr_i         (mem_addr_o),
    .mem_ack_i          (mem_ack_i),
    .instr_req_i        (instr_req_o),
    .instr_ack_i        (instr_ack_i),
    .instr_i            (instr_o),
    .instr_pc_i         (instr_pc_o),
    .instr_compressed_i (instr_compressed_o),
    .empty_i            (empty),
    .almost_empty_i     (almost_empty),
    .full_i             (wr_if.full)
  );

  ////////////////////////////////////////////////////////////////////
  // reporting and compares

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compare_word(input string name, input fetch_word_u got,
                              input fetch_word_u exp);
    if (got !== exp)
      stop_with_failure($sformatf("ERR %s got %h exp %h", name, got, exp));
  endtask

  task automatic compare_pc(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp)
      stop_with_failure($sformatf("ERR %s got %h exp %h", name, got, exp));
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_with_failure($sformatf("ERR %s got %h exp %h", name, got, exp));
  endtask

  ////////////////////////////////////////////////////////////////////
  // golden file and memory contents

  task automatic check_field_count(input int got, input int want, input string line);
    if (got != want)
      stop_with_failure({"malformed line in the golden file: ", line});
  endtask

  task automatic load_golden();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f0, f1, f2, f3, f4;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0)
      stop_with_failure("could not open the golden file");
    while ($fgets(line, fd) != 0)
    begin
      // blank lines and column notes
      if (line.len() < 2 || line.getc(0) == "#")
        continue;
      case (line.getc(0))
        "m":
        begin
          n = $sscanf(line, "m %h %h %h", f0, f1, f2);
          check_field_count(n, 3, line);
          img_addr.push_back(f0);
          img_data.push_back(f1);
          img_err.push_back(f2[0]);
        end
        "r":
        begin
          n = $sscanf(line, "r %h %h", f0, f1);
          check_field_count(n, 2, line);
          redirect_after  = f0;
          redirect_target = f1;
        end
        "e":
        begin
          n = $sscanf(line, "e %h %h %h %h %h", f0, f1, f2, f3, f4);
          check_field_count(n, 5, line);
          exp_pc.push_back(f0);
          exp_instr.push_back(f1);
          exp_cmp.push_back(f2[0]);
          exp_err.push_back(f3[0]);
          exp_delay.push_back(f4);
        end
        default:
          stop_with_failure({"unknown line in the golden file: ", line});
      endcase
    end
    $fclose(fd);
  endtask

  // unlisted words get a pattern of the full address
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    foreach (img_addr[n])
      if (img_addr[n] == addr)
        return img_data[n];
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h2c5a_91e3;
  endfunction

  function automatic logic err_at(input logic [31:0] addr);
    foreach (img_addr[n])
      if (img_addr[n] == addr)
        return img_err[n];
    return 1'b0;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // memory and core models, both on the falling edge

  // four-phase slave, answers after 0 to 3 cycles
  task automatic run_memory();
    int unsigned wait_cycles;
    forever
    begin
      @(negedge clk_i);
      if (mem_req_o)
      begin
        wait_cycles = $urandom % 4;
        repeat (wait_cycles)
          @(negedge clk_i);
        mem_rdata_i = word_at(mem_addr_o);
        mem_err_i   = err_at(mem_addr_o);
        mem_ack_i   = 1'b1;
        while (mem_req_o)
          @(negedge clk_i);
        mem_ack_i = 1'b0;
        mem_err_i = 1'b0;
      end
    end
  endtask

  // takes the stream in order, redirect after the given record
  task automatic run_core();
    int unsigned wait_cycles;
    for (int k = 0; k < exp_pc.size(); k++)
    begin
      while (!instr_req_o)
        @(negedge clk_i);
      compare_word("instr_o", instr_o, exp_instr[k]);
      compare_pc("instr_pc_o", instr_pc_o, exp_pc[k]);
      compare_flag("instr_compressed_o", instr_compressed_o, exp_cmp[k]);
      compare_flag("instr_err_o", instr_err_o, exp_err[k]);
      // long delays here back the queue up
      wait_cycles = ($urandom % 4) + exp_delay[k];
      repeat (wait_cycles)
        @(negedge clk_i);
      instr_ack_i = 1'b1;
      while (instr_req_o)
        @(negedge clk_i);
      instr_ack_i = 1'b0;
      if (k + 1 == redirect_after)
      begin
        redirect_i    = 1'b1;
        redirect_pc_i = redirect_target;
        @(negedge clk_i);
        redirect_i = 1'b0;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // clock, run and watchdog

  initial
  begin
    clk_i = 1'b0;
    forever
      #10 clk_i = ~clk_i;
  end

  initial
  begin
    rst_ni        = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    mem_ack_i     = 1'b0;
    mem_rdata_i   = '0;
    mem_err_i     = 1'b0;
    instr_ack_i   = 1'b0;
    void'($urandom(32'h8745));
    load_golden();
    watchdog_cycles = 200 * exp_pc.size();
    repeat (2)
      @(negedge clk_i);
    rst_ni = 1'b1;
    fork
      run_memory();
    join_none
    run_core();
    repeat (4)
      @(negedge clk_i);
    if (i_fetch_frontend.i_fetch_frontend_properties.fail_cnt == 0)
    begin
      $display("Simulation passed");
      $finish;
    end
    else
      stop_with_failure("a bound assertion failed during the run");
  end

  // stop at the first failed assertion
  always @(posedge clk_i)
  begin
    if (i_fetch_frontend.i_fetch_frontend_properties.fail_cnt != 0)
      stop_with_failure("a bound assertion on the bus, handshake or queue flags failed");
  end

  initial
  begin
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles)
      @(posedge clk_i);
    stop_with_failure("timeout, the instruction stream did not complete");
  end

endmodule

// ==== fetch_frontend.f ====
+incdir+common
common/ifq_pkg.sv
common/parcel_if.sv
hw/parcel_queue/parcel_queue.sv
hw/fetch_ctrl/fetch_ctrl.sv
hw/instr_aligner/instr_aligner.sv
hw/fetch_frontend.sv
verif/fetch_frontend_properties.sv
verif/fetch_frontend_tb.sv

// ==== verif/fetch_frontend_golden.txt ====
# m word_addr data bus_err | r records_before_redirect new_pc
# e pc instr compressed err extra_core_delay, every field in hex
m 00000000 00500093 0
m 00000004 00108133 0
m 00000008 002081b3 0
m 0000000c 05054505 0
m 00000010 85338082 0
m 00000014 458100c5 0
m 00000018 00a00593 0
m 0000001c 06054609 1
m 00000020 00b50633 0
m 00000040 4685dead 0
m 00000044 00d68733 0
m 00000048 40e787b3 0
m 0000004c 00f708b3 0
m 00000050 47010789 0
r c 00000042
e 00000000 00500093 0 0 0
e 00000004 00108133 0 0 0
e 00000008 002081b3 0 0 0
e 0000000c 00004505 1 0 0
e 0000000e 00000505 1 0 0
e 00000010 00008082 1 0 0
e 00000012 00c58533 0 0 0
e 00000016 00004581 1 0 0
e 00000018 00a00593 0 0 0
e 0000001c 00004609 1 1 0
e 0000001e 00000605 1 1 0
e 00000020 00b50633 0 0 0
e 00000042 00004685 1 0 0
e 00000044 00d68733 0 0 28
e 00000048 40e787b3 0 0 1e
e 0000004c 00f708b3 0 0 0
e 00000050 00000789 1 0 0
e 00000052 00004701 1 0 0
